/* sim.f */
+incdir+test
hdl/mixer_pkg.sv
hdl/mix_decode.sv
hdl/mix_execute.sv
hdl/mix_result.sv
hdl/channel_mixer.sv
test/tb_channel_mixer.sv

/* Bender.yml */
package:
  name: channel_mixer

sources:
  - hdl/mixer_pkg.sv
  - hdl/mix_decode.sv
  - hdl/mix_execute.sv
  - hdl/mix_result.sv
  - hdl/channel_mixer.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_channel_mixer.sv

/* test/tb_reference.svh */
// reference model for the channel mixer
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic sample_t clamp_sample(input int value);
    int max_val;
    int min_val;
    max_val = (1 << (SAMPLE_WIDTH - 1)) - 1;
    min_val = -(1 << (SAMPLE_WIDTH - 1));
    if (value > max_val) begin
        return sample_t'(max_val);
    end else if (value < min_val) begin
        return sample_t'(min_val);
    end
    return sample_t'(value);
endfunction

function automatic int op_value(input op_frame_t ops, input int index);
    return int'(ops[index]);  // sign extended
endfunction

function automatic expected_t reference_mix(input op_frame_t ops, input chan_cfg_frame_t cfg,
                                            input conn_sel_t sel);
    int sum_l;
    int sum_r;
    int ch;
    int first;
    int value;
    expected_t result;
    sum_l = 0;
    sum_r = 0;
    for (int b = 0; b < NUM_BANKS; b++) begin
        for (int k = 0; k < CHANS_PER_BANK; k++) begin
            ch = b * CHANS_PER_BANK + k;
            if (k < 3) begin
                first = b * OPS_PER_BANK + k;
            end else if (k < 6) begin
                first = b * OPS_PER_BANK + k + 3;
            end else begin
                first = b * OPS_PER_BANK + k + 6;
            end
            if (k < 3 && sel[b * 3 + k]) begin
                case ({cfg[ch].cnt, cfg[ch + 3].cnt})
                    2'b00: value = op_value(ops, first + 9);
                    2'b01: value = op_value(ops, first + 3) + op_value(ops, first + 9);
                    2'b10: value = op_value(ops, first) + op_value(ops, first + 9);
                    default: value = op_value(ops, first) + op_value(ops, first + 6)
                        + op_value(ops, first + 9);
                endcase
            end else if (k >= 3 && k < 6 && sel[b * 3 + k - 3]) begin
                value = 0;  // partner of a 4-op pair
            end else if (cfg[ch].cnt) begin
                value = op_value(ops, first) + op_value(ops, first + 3);
            end else begin
                value = op_value(ops, first + 3);
            end
            if (cfg[ch].left_en) sum_l += value;
            if (cfg[ch].right_en) sum_r += value;
        end
    end
    result.left = clamp_sample(sum_l);
    result.right = clamp_sample(sum_r);
    return result;
endfunction

`endif

/* test/tb_channel_mixer.sv */
// channel mixer testbench
`timescale 1ns/1ps

module tb_channel_mixer
    import mixer_pkg::*;
();

    localparam int SAMPLE_WIDTH = 16;
    localparam int DRAIN_CYCLES = 60;  // well above the 20-cycle latency

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } expected_t;

    logic            clk;
    logic            reset;
    logic            op_valid;
    op_frame_t       op_out;
    chan_cfg_frame_t chan_cfg;
    conn_sel_t       connection_sel;
    logic            sample_valid;
    sample_t         sample_l;
    sample_t         sample_r;

    expected_t   expected_q[$];
    logic [31:0] rng_state = 32'hd5f9_ecef;

    `include "tb_reference.svh"

    channel_mixer #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) dut (
        .clk            (clk),
        .reset          (reset),
        .op_valid       (op_valid),
        .op_out         (op_out),
        .chan_cfg       (chan_cfg),
        .connection_sel (connection_sel),
        .sample_valid   (sample_valid),
        .sample_l       (sample_l),
        .sample_r       (sample_r)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;  // 8 ns period

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic op_frame_t random_ops();
        op_frame_t ops;
        for (int i = 0; i < NUM_OPS; i++) ops[i] = op_t'(rand32());
        return ops;
    endfunction

    function automatic chan_cfg_frame_t random_cfg();
        chan_cfg_frame_t cfg;
        logic [31:0] r;
        for (int c = 0; c < NUM_CHANS; c++) begin
            r = rand32();
            cfg[c] = chan_cfg_t'(r[2:0]);
        end
        return cfg;
    endfunction

    function automatic chan_cfg_frame_t set_routing(input chan_cfg_frame_t cfg,
                                                    input logic left, input logic right);
        for (int c = 0; c < NUM_CHANS; c++) begin
            cfg[c].left_en = left;
            cfg[c].right_en = right;
        end
        return cfg;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "testbench stopped after the first error");
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL time=%0t %s got=%0d expected=%0d",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL time=%0t %s got=%b expected=%b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input op_frame_t ops, input chan_cfg_frame_t cfg,
                              input conn_sel_t sel);
        op_out = ops;
        chan_cfg = cfg;
        connection_sel = sel;
        op_valid = 1'b1;
        expected_q.push_back(reference_mix(ops, cfg, sel));
        next_cycle();
        op_valid = 1'b0;
        op_out = random_ops();  // inputs matter only with the strobe
    endtask

    task automatic send_spaced(input op_frame_t ops, input chan_cfg_frame_t cfg,
                               input conn_sel_t sel);
        send_frame(ops, cfg, sel);
        repeat (19) next_cycle();  // strobes exactly 20 cycles apart
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0) begin
            if (cycles == DRAIN_CYCLES) stop_with_failure("timed out waiting for sample_valid");
            next_cycle();
            cycles++;
        end
    endtask

    // compares every sample against the oldest pending frame
    always @(negedge clk) begin : compare_samples
        expected_t exp;
        if (sample_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                stop_with_failure("sample_valid arrived with no frame pending");
            end else begin
                exp = expected_q.pop_front();
                check_sample("sample_l", sample_l, exp.left);
                check_sample("sample_r", sample_r, exp.right);
            end
        end
    end

    initial begin : stimulus
        chan_cfg_frame_t cfg;
        op_frame_t       ops;
        logic [1:0]      pick;
        op_valid = 1'b0;
        op_out = '0;
        chan_cfg = '0;
        connection_sel = '0;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;

        // reset state then exact latency of one frame
        for (int i = 0; i < 5; i++) begin
            check_strobe("sample_valid", sample_valid, 1'b0);
            next_cycle();
        end
        check_sample("sample_l", sample_l, '0);
        check_sample("sample_r", sample_r, '0);
        send_frame(random_ops(), set_routing(random_cfg(), 1'b1, 1'b1), '0);
        for (int n = 1; n <= 22; n++) begin
            next_cycle();
            check_strobe("sample_valid", sample_valid, n == 20);
        end
        wait_for_drain();

        // 2-op channels only
        for (int i = 0; i < 10; i++) begin
            send_spaced(random_ops(), set_routing(random_cfg(), 1'b1, 1'b1), '0);
        end
        wait_for_drain();

        // every cnt combination on every 4-op pair
        for (int combo = 0; combo < 4; combo++) begin
            cfg = set_routing(random_cfg(), 1'b1, 1'b1);
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int i = 0; i < 3; i++) begin
                    pick = 2'(combo + i);
                    cfg[b * CHANS_PER_BANK + i].cnt = pick[1];
                    cfg[b * CHANS_PER_BANK + i + 3].cnt = pick[0];
                end
            end
            send_spaced(random_ops(), cfg, '1);
        end
        wait_for_drain();

        // routing with every side off in the first frame
        for (int i = 0; i < 8; i++) begin
            cfg = random_cfg();
            if (i == 0) cfg = set_routing(cfg, 1'b0, 1'b0);
            send_spaced(random_ops(), cfg, conn_sel_t'(rand32()));
        end
        wait_for_drain();

        // saturation at both ends
        for (int i = 0; i < NUM_OPS; i++) ops[i] = op_t'((1 << (OP_WIDTH - 1)) - 1);
        cfg = '1;
        send_spaced(ops, cfg, '0);
        wait_for_drain();
        check_sample("sample_l", sample_l, sample_t'(32767));
        check_sample("sample_r", sample_r, sample_t'(32767));
        for (int i = 0; i < NUM_OPS; i++) ops[i] = op_t'(-(1 << (OP_WIDTH - 1)));
        send_spaced(ops, cfg, '0);
        wait_for_drain();
        check_sample("sample_l", sample_l, sample_t'(-32768));
        check_sample("sample_r", sample_r, sample_t'(-32768));

        // random frames at the minimum spacing
        for (int i = 0; i < 50; i++) begin
            send_spaced(random_ops(), random_cfg(), conn_sel_t'(rand32()));
        end
        wait_for_drain();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* hdl/channel_mixer.sv */
// FM channel mixer top level
`timescale 1ns/1ps

module channel_mixer
    import mixer_pkg::*;
#(
    parameter int SAMPLE_WIDTH = 16  // 8 to 20
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           op_valid,
    input  op_frame_t                      op_out,
    input  chan_cfg_frame_t                chan_cfg,
    input  conn_sel_t                      connection_sel,
    output logic                           sample_valid,
    output logic signed [SAMPLE_WIDTH-1:0] sample_l,
    output logic signed [SAMPLE_WIDTH-1:0] sample_r
);

    logic            chans_valid;
    chan_mix_frame_t chans;
    logic            sums_valid;
    acc_t            sum_l;
    acc_t            sum_r;

    mix_decode u_decode (
        .clk            (clk),
        .reset          (reset),
        .op_valid       (op_valid),
        .op_out         (op_out),
        .chan_cfg       (chan_cfg),
        .connection_sel (connection_sel),
        .chans_valid    (chans_valid),
        .chans          (chans)
    );

    mix_execute u_execute (
        .clk         (clk),
        .reset       (reset),
        .chans_valid (chans_valid),
        .chans       (chans),
        .sums_valid  (sums_valid),
        .sum_l       (sum_l),
        .sum_r       (sum_r)
    );

    mix_result #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) u_result (
        .clk          (clk),
        .reset        (reset),
        .sums_valid   (sums_valid),
        .sum_l        (sum_l),
        .sum_r        (sum_r),
        .sample_valid (sample_valid),
        .sample_l     (sample_l),
        .sample_r     (sample_r)
    );

endmodule

/* hdl/mix_result.sv */
// output clamp
`timescale 1ns/1ps

module mix_result
    import mixer_pkg::*;
#(
    parameter int SAMPLE_WIDTH = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           sums_valid,
    input  acc_t                           sum_l,
    input  acc_t                           sum_r,
    output logic                           sample_valid,
    output logic signed [SAMPLE_WIDTH-1:0] sample_l,
    output logic signed [SAMPLE_WIDTH-1:0] sample_r
);

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    localparam acc_t SAT_MAX = acc_t'(2 ** (SAMPLE_WIDTH - 1) - 1);
    localparam acc_t SAT_MIN = acc_t'(-(2 ** (SAMPLE_WIDTH - 1)));

    function automatic sample_t saturate(input acc_t value);
        if (value > SAT_MAX) begin
            return sample_t'(SAT_MAX);
        end else if (value < SAT_MIN) begin
            return sample_t'(SAT_MIN);
        end
        return sample_t'(value);  // in range, just drop the top bits
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            sample_valid <= 1'b0;
            sample_l     <= '0;
            sample_r     <= '0;
        end else begin
            sample_valid <= sums_valid;
            if (sums_valid) begin
                sample_l <= saturate(sum_l);
                sample_r <= saturate(sum_r);  // held until next frame
            end
        end
    end

endmodule

/* hdl/mix_execute.sv */
// channel accumulation sequencer
`timescale 1ns/1ps

module mix_execute
    import mixer_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            chans_valid,
    input  chan_mix_frame_t chans,
    output logic            sums_valid,
    output acc_t            sum_l,
    output acc_t            sum_r
);

    localparam int IDX_WIDTH = $clog2(NUM_CHANS);
    localparam logic [IDX_WIDTH-1:0] LAST_CHAN = IDX_WIDTH'(NUM_CHANS - 1);

    exec_state_t           state;
    logic [IDX_WIDTH-1:0]  chan_idx;
    chan_mix_frame_t       frame;  // private copy, decode may move on

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            chan_idx   <= '0;
            sums_valid <= 1'b0;
        end else begin
            sums_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (chans_valid) begin
                        chan_idx <= '0;
                        state    <= ACCUMULATE;
                    end
                end
                ACCUMULATE: begin
                    chan_idx <= chan_idx + 1'b1;
                    if (chan_idx == LAST_CHAN) begin
                        state      <= IDLE;
                        sums_valid <= 1'b1;  // final add lands this edge
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && chans_valid) begin
            frame <= chans;
            sum_l <= '0;
            sum_r <= '0;
        end else if (state == ACCUMULATE) begin
            sum_l <= sum_l + acc_t'(frame[chan_idx].left);   // sign extended
            sum_r <= sum_r + acc_t'(frame[chan_idx].right);
        end
    end

endmodule

/* hdl/mix_decode.sv */
// operator to channel decode
`timescale 1ns/1ps

module mix_decode
    import mixer_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            op_valid,
    input  op_frame_t       op_out,
    input  chan_cfg_frame_t chan_cfg,
    input  conn_sel_t       connection_sel,
    output logic            chans_valid,
    output chan_mix_frame_t chans
);

    chan_mix_t chan_next [NUM_CHANS];  // routed values before the register

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        for (genvar k = 0; k < CHANS_PER_BANK; k++) begin : g_chan
            // slots k, k+3 for channels 0-2; shifted by 3 per group of three
            localparam int FIRST = b * OPS_PER_BANK + k + 3 * (k / 3);
            localparam int SECOND = FIRST + 3;
            localparam int CH = b * CHANS_PER_BANK + k;

            chan_t two_op;
            chan_t chan_val;

            // 2-op: additive when cnt set, else modulator feeds carrier
            assign two_op = chan_cfg[CH].cnt
                ? chan_t'(op_out[FIRST]) + chan_t'(op_out[SECOND])
                : chan_t'(op_out[SECOND]);

            if (k < PAIRS_PER_BANK) begin : g_pair
                localparam int SEL = b * PAIRS_PER_BANK + k;

                chan_t four_op;

                always_comb begin
                    case ({chan_cfg[CH].cnt, chan_cfg[CH + PAIRS_PER_BANK].cnt})
                        2'b00: begin
                            four_op = chan_t'(op_out[FIRST + 9]);
                        end
                        2'b01: begin
                            four_op = chan_t'(op_out[FIRST + 3])
                                + chan_t'(op_out[FIRST + 9]);
                        end
                        2'b10: begin
                            four_op = chan_t'(op_out[FIRST])
                                + chan_t'(op_out[FIRST + 9]);
                        end
                        default: begin  // three carriers summed
                            four_op = chan_t'(op_out[FIRST])
                                + chan_t'(op_out[FIRST + 6])
                                + chan_t'(op_out[FIRST + 9]);
                        end
                    endcase
                end

                assign chan_val = connection_sel[SEL] ? four_op : two_op;
            end else if (k < 2 * PAIRS_PER_BANK) begin : g_partner
                localparam int SEL = b * PAIRS_PER_BANK + k - PAIRS_PER_BANK;

                // operators already used by the 4-op partner
                assign chan_val = connection_sel[SEL] ? chan_t'(0) : two_op;
            end else begin : g_plain
                assign chan_val = two_op;
            end

            assign chan_next[CH] = '{
                left:  chan_cfg[CH].left_en  ? chan_val : chan_t'(0),
                right: chan_cfg[CH].right_en ? chan_val : chan_t'(0)
            };
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            chans_valid <= 1'b0;
        end else begin
            chans_valid <= op_valid;  // one cycle behind the strobe
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            for (int c = 0; c < NUM_CHANS; c++) begin
                chans[c] <= chan_next[c];
            end
        end
    end

endmodule

/* hdl/mixer_pkg.sv */
// channel mixer shared types
package mixer_pkg;

    localparam int OP_WIDTH        = 13;
    localparam int NUM_BANKS       = 2;
    localparam int OPS_PER_BANK    = 18;
    localparam int CHANS_PER_BANK  = 9;
    localparam int NUM_CHANS       = NUM_BANKS * CHANS_PER_BANK;
    localparam int NUM_OPS         = NUM_BANKS * OPS_PER_BANK;
    localparam int PAIRS_PER_BANK  = 3;   // channels 0-2 can join with 3-5

    localparam int CHAN_WIDTH      = OP_WIDTH + 2;    // room for three operators
    localparam int ACC_WIDTH       = CHAN_WIDTH + 5;  // room for 18 channels

    // one signed operator output
    typedef logic signed [OP_WIDTH-1:0] op_t;

    // index is bank * OPS_PER_BANK + slot
    typedef op_t [NUM_OPS-1:0] op_frame_t;

    typedef logic signed [CHAN_WIDTH-1:0] chan_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;

    // bit bank * PAIRS_PER_BANK + i enables 4-op on pair i
    typedef logic [NUM_BANKS*PAIRS_PER_BANK-1:0] conn_sel_t;

    typedef struct packed {
        logic cnt;       // connection type
        logic left_en;   // route to left output
        logic right_en;  // route to right output
    } chan_cfg_t;

    // index is bank * CHANS_PER_BANK + channel
    typedef chan_cfg_t [NUM_CHANS-1:0] chan_cfg_frame_t;

    typedef struct packed {
        chan_t left;
        chan_t right;
    } chan_mix_t;

    typedef chan_mix_t [NUM_CHANS-1:0] chan_mix_frame_t;

    typedef enum logic {
        IDLE,
        ACCUMULATE
    } exec_state_t;

endpackage
